//--- source/mipsPkg.sv
package mipsPkg;

	// Primary opcode field, MIPS encodings
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddiu   = 6'h09,
		opOri     = 6'h0d,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeE;

	// R-type function field
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} functE;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOpE;

	// Operand source for forwarding
	typedef enum logic [1:0] {
		fwdReg,
		fwdMem,
		fwdWb
	} fwdSelE;

endpackage

//--- source/stageIfs.sv
`timescale 1ns/10ps

interface decExIf;
	logic [31:0] pc;
	mipsPkg::aluOpE aluOp;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic [31:0] imm32;
	logic useImm;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] dest;
	logic regWrite;
	logic memRead;
	logic memWrite;

	modport source(output pc, aluOp, rsVal, rtVal, imm32, useImm, rs, rt, dest,
		regWrite, memRead, memWrite);
	modport sink(input pc, aluOp, rsVal, rtVal, imm32, useImm, rs, rt, dest,
		regWrite, memRead, memWrite);
endinterface

interface exMemIf;
	logic [31:0] pc;
	logic [31:0] aluResult;
	logic [4:0] dest;
	logic regWrite;
	logic memRead;

	modport source(output pc, aluResult, dest, regWrite, memRead);
	modport sink(input pc, aluResult, dest, regWrite, memRead);
endinterface

interface memWbIf;
	logic [31:0] pc;
	logic [31:0] result;
	logic [4:0] dest;
	logic regWrite;

	modport source(output pc, result, dest, regWrite);
	modport sink(input pc, result, dest, regWrite);
endinterface

//--- source/fetchStage.sv
`timescale 1ns/10ps

module fetchStage #(
	parameter logic [31:0] resetPc = 32'hBFC00000
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic        stall,
	input  logic        branchTaken,
	input  logic [31:0] branchTarget,
	input  logic [31:0] instSramRdata,
	output logic        instSramEn,
	output logic [31:0] instSramAddr,
	output logic [31:0] idPc,
	output logic [31:0] idInstr
);
	logic [31:0] pc;
	logic [31:0] nextPc;
	logic fetchValid;

	always_comb begin
		if (stall) begin
			nextPc = pc;
		end else if (branchTaken) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pc + 32'd4;
		end
	end

	// Fetch runs whenever the core is out of reset
	assign instSramEn = rstN;
	assign instSramAddr = nextPc;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc - 32'd4;
			fetchValid <= 1'b0;
			idPc <= '0;
			idInstr <= '0;
		end else begin
			pc <= nextPc;
			fetchValid <= 1'b1;
			if (!stall) begin
				idPc <= pc;
				// Nothing was requested for resetPc - 4, so pass a no-op
				idInstr <= fetchValid ? instSramRdata : 32'd0;
			end
		end
	end

	// Branch targets from decode keep word alignment
	aInstAligned: assert property (@(posedge clk) disable iff (!rstN)
		instSramAddr[1:0] == 2'b00);

endmodule

//--- source/regFile.sv
`timescale 1ns/10ps

module regFile (
	input  logic        clk,
	input  logic        rstN,
	input  logic [4:0]  rdAddrA,
	input  logic [4:0]  rdAddrB,
	output logic [31:0] rdDataA,
	output logic [31:0] rdDataB,
	memWbIf.sink        wb
);
	logic [31:0] regs [0:31];

	// Write-first, so a writeback in this cycle is seen by decode
	function automatic logic [31:0] readReg(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return 32'd0;
		end
		if (wb.regWrite && wb.dest == addr) begin
			return wb.result;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdDataA = readReg(rdAddrA);
		rdDataB = readReg(rdAddrB);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.regWrite && wb.dest != 5'd0) begin
			regs[wb.dest] <= wb.result;
		end
	end

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
	input  logic            clk,
	input  logic            rstN,
	input  logic [4:0]      idRs,
	input  logic [4:0]      idRt,
	input  logic            idUsesRt,
	input  logic            idIsBranch,
	decExIf.sink            de,
	exMemIf.sink            em,
	memWbIf.sink            wb,
	output logic            stall,
	output mipsPkg::fwdSelE fwdA,
	output mipsPkg::fwdSelE fwdB,
	output mipsPkg::fwdSelE fwdBrA,
	output mipsPkg::fwdSelE fwdBrB
);
	logic memWr;
	logic wbWr;
	logic exHit;

	// Register 0 is never a forwarding target
	assign memWr = em.regWrite && em.dest != 5'd0;
	assign wbWr = wb.regWrite && wb.dest != 5'd0;

	// Memory stage wins over writeback, it is the younger result
	function automatic mipsPkg::fwdSelE pickFwd(input logic [4:0] src, input logic allowWb);
		if (memWr && em.dest == src) begin
			return mipsPkg::fwdMem;
		end
		if (allowWb && wbWr && wb.dest == src) begin
			return mipsPkg::fwdWb;
		end
		return mipsPkg::fwdReg;
	endfunction

	always_comb begin
		fwdA = pickFwd(de.rs, 1'b1);
		fwdB = pickFwd(de.rt, 1'b1);
		// Decode reads writeback through the register file bypass
		fwdBrA = pickFwd(idRs, 1'b0);
		fwdBrB = pickFwd(idRt, 1'b0);
	end

	assign exHit = de.regWrite && de.dest != 5'd0 &&
		(de.dest == idRs || (idUsesRt && de.dest == idRt));
	assign stall = exHit && (de.memRead || idIsBranch);

	// The bubble behind a stall can never cause a second one
	aStallOnce: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> !stall);

endmodule

//--- source/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
	input  logic            clk,
	input  logic            rstN,
	input  logic [31:0]     idPc,
	input  logic [31:0]     idInstr,
	input  logic            stall,
	input  mipsPkg::fwdSelE fwdBrA,
	input  mipsPkg::fwdSelE fwdBrB,
	input  logic [31:0]     memResult,
	output logic            branchTaken,
	output logic [31:0]     branchTarget,
	output logic [4:0]      idRs,
	output logic [4:0]      idRt,
	output logic            idUsesRt,
	output logic            idIsBranch,
	decExIf.source          de,
	memWbIf.sink            wb
);
	mipsPkg::opcodeE opcode;
	mipsPkg::functE funct;
	mipsPkg::aluOpE aluOp;
	logic [31:0] rdA;
	logic [31:0] rdB;
	logic [31:0] brA;
	logic [31:0] brB;
	logic [31:0] imm32;
	logic [4:0] dest;
	logic useImm;
	logic signExt;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic isBne;

	assign opcode = mipsPkg::opcodeE'(idInstr[31:26]);
	assign funct = mipsPkg::functE'(idInstr[5:0]);
	assign idRs = idInstr[25:21];
	assign idRt = idInstr[20:16];

	regFile uRegFile (
		.clk(clk), .rstN(rstN),
		.rdAddrA(idRs), .rdAddrB(idRt),
		.rdDataA(rdA), .rdDataB(rdB),
		.wb(wb)
	);

	always_comb begin
		aluOp = mipsPkg::aluAdd;
		useImm = 1'b0;
		signExt = 1'b1;
		dest = idInstr[20:16];
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		idUsesRt = 1'b0;
		idIsBranch = 1'b0;
		case (opcode)
			mipsPkg::opSpecial: begin
				dest = idInstr[15:11];
				idUsesRt = 1'b1;
				regWrite = 1'b1;
				case (funct)
					mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
					default:         regWrite = 1'b0;
				endcase
			end
			mipsPkg::opAddiu: begin
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			mipsPkg::opOri: begin
				aluOp = mipsPkg::aluOr;
				useImm = 1'b1;
				signExt = 1'b0;
				regWrite = 1'b1;
			end
			mipsPkg::opLui: begin
				aluOp = mipsPkg::aluLui;
				useImm = 1'b1;
				signExt = 1'b0;
				regWrite = 1'b1;
			end
			mipsPkg::opLw: begin
				useImm = 1'b1;
				regWrite = 1'b1;
				memRead = 1'b1;
			end
			mipsPkg::opSw: begin
				useImm = 1'b1;
				memWrite = 1'b1;
				idUsesRt = 1'b1;
			end
			mipsPkg::opBeq, mipsPkg::opBne: begin
				idIsBranch = 1'b1;
				idUsesRt = 1'b1;
			end
			// Anything else retires as a no-op
			default: ;
		endcase
	end

	assign imm32 = signExt ? {{16{idInstr[15]}}, idInstr[15:0]} : {16'd0, idInstr[15:0]};

	// Branch compare
	assign brA = (fwdBrA == mipsPkg::fwdMem) ? memResult : rdA;
	assign brB = (fwdBrB == mipsPkg::fwdMem) ? memResult : rdB;
	assign isBne = (opcode == mipsPkg::opBne);
	assign branchTarget = idPc + 32'd4 + {{14{idInstr[15]}}, idInstr[15:0], 2'b00};
	assign branchTaken = idIsBranch && !stall && ((brA == brB) != isBne);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			de.regWrite <= 1'b0;
			de.memRead <= 1'b0;
			de.memWrite <= 1'b0;
		end else begin
			// Stall sends a bubble
			de.regWrite <= regWrite && !stall;
			de.memRead <= memRead && !stall;
			de.memWrite <= memWrite && !stall;
		end
	end

	always_ff @(posedge clk) begin
		de.pc <= idPc;
		de.aluOp <= aluOp;
		de.rsVal <= rdA;
		de.rtVal <= rdB;
		de.imm32 <= imm32;
		de.useImm <= useImm;
		de.rs <= idRs;
		de.rt <= idRt;
		de.dest <= dest;
	end

	aNoBranchInStall: assert property (@(posedge clk) disable iff (!rstN)
		stall |-> !branchTaken);

endmodule

//--- source/executeStage.sv
`timescale 1ns/10ps

module executeStage (
	input  logic            clk,
	input  logic            rstN,
	input  mipsPkg::fwdSelE fwdA,
	input  mipsPkg::fwdSelE fwdB,
	input  logic [31:0]     memResult,
	decExIf.sink            de,
	memWbIf.sink            wb,
	exMemIf.source          em,
	output logic            dataSramEn,
	output logic [3:0]      dataSramWen,
	output logic [31:0]     dataSramAddr,
	output logic [31:0]     dataSramWdata
);
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluB;
	logic [31:0] aluResult;

	function automatic logic [31:0] fwdMux(input mipsPkg::fwdSelE sel, input logic [31:0] regVal,
			input logic [31:0] memVal, input logic [31:0] wbVal);
		case (sel)
			mipsPkg::fwdMem: return memVal;
			mipsPkg::fwdWb:  return wbVal;
			default:         return regVal;
		endcase
	endfunction

	assign opA = fwdMux(fwdA, de.rsVal, memResult, wb.result);
	assign opB = fwdMux(fwdB, de.rtVal, memResult, wb.result);
	assign aluB = de.useImm ? de.imm32 : opB;

	always_comb begin
		case (de.aluOp)
			mipsPkg::aluSub: aluResult = opA - aluB;
			mipsPkg::aluAnd: aluResult = opA & aluB;
			mipsPkg::aluOr:  aluResult = opA | aluB;
			mipsPkg::aluSlt: aluResult = {31'd0, $signed(opA) < $signed(aluB)};
			mipsPkg::aluLui: aluResult = {aluB[15:0], 16'd0};
			default:         aluResult = opA + aluB;
		endcase
	end

	// LW and SW decode to aluAdd, so this is rsVal plus imm32
	assign dataSramAddr = aluResult;
	assign dataSramEn = de.memRead || de.memWrite;
	assign dataSramWen = {4{de.memWrite}};
	assign dataSramWdata = opB;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			em.regWrite <= 1'b0;
			em.memRead <= 1'b0;
		end else begin
			em.regWrite <= de.regWrite;
			em.memRead <= de.memRead;
		end
	end

	always_ff @(posedge clk) begin
		em.pc <= de.pc;
		em.aluResult <= aluResult;
		em.dest <= de.dest;
	end

	aWenWhole: assert property (@(posedge clk) disable iff (!rstN)
		dataSramWen inside {4'h0, 4'hf});
	// A store never turns into a register write downstream
	aStoreNoWb: assert property (@(posedge clk) disable iff (!rstN)
		(|dataSramWen) |=> !em.regWrite);

endmodule

//--- source/memWbStage.sv
`timescale 1ns/10ps

module memWbStage (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] dataSramRdata,
	exMemIf.sink        em,
	memWbIf.source      wb,
	output logic [31:0] memResult,
	output logic [31:0] debugWbPc,
	output logic [3:0]  debugWbRfWen,
	output logic [4:0]  debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);
	// Load data arrives from the SRAM in this stage
	assign memResult = em.memRead ? dataSramRdata : em.aluResult;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wb.regWrite <= 1'b0;
		end else begin
			wb.regWrite <= em.regWrite;
		end
	end

	always_ff @(posedge clk) begin
		wb.pc <= em.pc;
		wb.result <= memResult;
		wb.dest <= em.dest;
	end

	// Debug trace
	assign debugWbPc = wb.pc;
	assign debugWbRfWen = {4{wb.regWrite}};
	assign debugWbRfWnum = wb.dest;
	assign debugWbRfWdata = wb.result;

endmodule

//--- source/mipsLite.sv
`timescale 1ns/10ps

module mipsLite #(
	parameter logic [31:0] resetPc = 32'hBFC00000
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] instSramRdata,
	input  logic [31:0] dataSramRdata,
	output logic        instSramEn,
	output logic [31:0] instSramAddr,
	output logic        dataSramEn,
	output logic [3:0]  dataSramWen,
	output logic [31:0] dataSramAddr,
	output logic [31:0] dataSramWdata,
	output logic [31:0] debugWbPc,
	output logic [3:0]  debugWbRfWen,
	output logic [4:0]  debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);
	logic stall;
	logic branchTaken;
	logic [31:0] branchTarget;
	logic [31:0] idPc;
	logic [31:0] idInstr;
	logic [31:0] memResult;
	logic [4:0] idRs;
	logic [4:0] idRt;
	logic idUsesRt;
	logic idIsBranch;
	mipsPkg::fwdSelE fwdA;
	mipsPkg::fwdSelE fwdB;
	mipsPkg::fwdSelE fwdBrA;
	mipsPkg::fwdSelE fwdBrB;

	decExIf deBus ();
	exMemIf emBus ();
	memWbIf wbBus ();

	fetchStage #(.resetPc(resetPc)) uFetch (
		.clk(clk), .rstN(rstN), .stall(stall),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.instSramRdata(instSramRdata), .instSramEn(instSramEn),
		.instSramAddr(instSramAddr), .idPc(idPc), .idInstr(idInstr)
	);

	decodeStage uDecode (
		.clk(clk), .rstN(rstN), .idPc(idPc), .idInstr(idInstr), .stall(stall),
		.fwdBrA(fwdBrA), .fwdBrB(fwdBrB), .memResult(memResult),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.idRs(idRs), .idRt(idRt), .idUsesRt(idUsesRt), .idIsBranch(idIsBranch),
		.de(deBus), .wb(wbBus)
	);

	executeStage uExecute (
		.clk(clk), .rstN(rstN), .fwdA(fwdA), .fwdB(fwdB), .memResult(memResult),
		.de(deBus), .wb(wbBus), .em(emBus),
		.dataSramEn(dataSramEn), .dataSramWen(dataSramWen),
		.dataSramAddr(dataSramAddr), .dataSramWdata(dataSramWdata)
	);

	memWbStage uMemWb (
		.clk(clk), .rstN(rstN), .dataSramRdata(dataSramRdata),
		.em(emBus), .wb(wbBus), .memResult(memResult),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

	hazardUnit uHazard (
		.clk(clk), .rstN(rstN), .idRs(idRs), .idRt(idRt),
		.idUsesRt(idUsesRt), .idIsBranch(idIsBranch),
		.de(deBus), .em(emBus), .wb(wbBus), .stall(stall),
		.fwdA(fwdA), .fwdB(fwdB), .fwdBrA(fwdBrA), .fwdBrB(fwdBrB)
	);

endmodule

//--- dv/tbClock.sv
`timescale 1ns/10ps

module tbClock (
	output logic clk,
	output logic rstN
);
	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		// Reset spans four rising edges
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
	end

	always #4 clk = ~clk;

endmodule

//--- dv/mipsLiteTb.sv
`timescale 1ns/10ps

module mipsLiteTb;
	localparam logic [31:0] resetPc = 32'hBFC00000;
	localparam int progLen = 40;
	localparam int wbTimeout = 200;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0] num;
		logic [31:0] val;
		logic [2:0] tag;
	} wbEntryT;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} stEntryT;

	logic clk;
	logic rstN;
	logic [31:0] instSramRdata = '0;
	logic [31:0] dataSramRdata = '0;
	logic instSramEn;
	logic [31:0] instSramAddr;
	logic dataSramEn;
	logic [3:0] dataSramWen;
	logic [31:0] dataSramAddr;
	logic [31:0] dataSramWdata;
	logic [31:0] debugWbPc;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	logic [31:0] rom [0:63];
	logic [31:0] ram [0:63];
	logic [31:0] lcgState = 32'ha0f7;
	wbEntryT expWb [$];
	stEntryT expSt [$];
	wbEntryT wantWb;
	stEntryT wantSt;
	int passCnt [1:6] = '{default: 0};
	int failCnt [1:6] = '{default: 0};
	logic firstChecked = 1'b0;

	tbClock uClock (.clk(clk), .rstN(rstN));

	mipsLite #(.resetPc(resetPc)) u_dut (
		.clk(clk), .rstN(rstN),
		.instSramRdata(instSramRdata), .dataSramRdata(dataSramRdata),
		.instSramEn(instSramEn), .instSramAddr(instSramAddr),
		.dataSramEn(dataSramEn), .dataSramWen(dataSramWen),
		.dataSramAddr(dataSramAddr), .dataSramWdata(dataSramWdata),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

	function automatic logic [15:0] nextImm();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[31:16];
	endfunction

	function automatic logic [31:0] fillWord(input int i);
		return 32'hc3a5_0000 ^ (32'(i) * 32'h0101_0007);
	endfunction

	function automatic logic [31:0] rTypeWord(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input mipsPkg::functE fn);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iTypeWord(input mipsPkg::opcodeE op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Past the program the ROM reads as no-ops
	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - resetPc) >> 2;
		return (idx < 32'd64) ? rom[idx[5:0]] : 32'd0;
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < 64; i++) begin
			rom[i] = 32'd0;
			ram[i] = fillWord(i);
		end
		rom[0] = iTypeWord(mipsPkg::opLui, 5'd0, 5'd1, nextImm());
		rom[1] = iTypeWord(mipsPkg::opOri, 5'd1, 5'd1, nextImm());
		rom[2] = iTypeWord(mipsPkg::opLui, 5'd0, 5'd2, nextImm());
		rom[3] = iTypeWord(mipsPkg::opOri, 5'd2, 5'd2, nextImm());
		rom[4] = rTypeWord(5'd1, 5'd2, 5'd3, mipsPkg::fnAddu);
		rom[5] = rTypeWord(5'd3, 5'd1, 5'd4, mipsPkg::fnSubu);
		rom[6] = rTypeWord(5'd4, 5'd2, 5'd5, mipsPkg::fnAnd);
		rom[7] = rTypeWord(5'd5, 5'd3, 5'd6, mipsPkg::fnOr);
		rom[8] = rTypeWord(5'd1, 5'd2, 5'd7, mipsPkg::fnSlt);
		rom[9] = rTypeWord(5'd2, 5'd1, 5'd8, mipsPkg::fnSlt);
		rom[10] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd10, 16'h0040);
		rom[11] = iTypeWord(mipsPkg::opSw, 5'd10, 5'd3, 16'd0);
		rom[12] = iTypeWord(mipsPkg::opSw, 5'd10, 5'd4, 16'd4);
		rom[13] = iTypeWord(mipsPkg::opLw, 5'd10, 5'd11, 16'd0);
		rom[14] = rTypeWord(5'd11, 5'd1, 5'd12, mipsPkg::fnAddu);
		rom[15] = iTypeWord(mipsPkg::opLw, 5'd10, 5'd13, 16'd4);
		rom[16] = iTypeWord(mipsPkg::opSw, 5'd10, 5'd13, 16'd8);
		rom[17] = iTypeWord(mipsPkg::opLw, 5'd10, 5'd14, 16'd12);
		rom[18] = rTypeWord(5'd14, 5'd0, 5'd15, mipsPkg::fnOr);
		rom[19] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd0, 16'h0055);
		rom[20] = rTypeWord(5'd0, 5'd0, 5'd9, mipsPkg::fnAddu);
		rom[21] = iTypeWord(mipsPkg::opBeq, 5'd1, 5'd1, 16'd3);
		rom[22] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd16, 16'd1);
		rom[23] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd17, 16'd2);
		rom[24] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd17, 16'd3);
		rom[25] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd18, 16'd4);
		rom[26] = iTypeWord(mipsPkg::opBeq, 5'd18, 5'd0, 16'd2);
		rom[27] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd19, 16'd5);
		rom[28] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd20, 16'd6);
		rom[29] = rTypeWord(5'd7, 5'd8, 5'd21, mipsPkg::fnAddu);
		rom[30] = iTypeWord(mipsPkg::opBne, 5'd21, 5'd0, 16'd2);
		rom[31] = iTypeWord(mipsPkg::opSw, 5'd10, 5'd21, 16'd16);
		rom[32] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd22, 16'd7);
		rom[33] = iTypeWord(mipsPkg::opLw, 5'd10, 5'd23, 16'd16);
		rom[34] = iTypeWord(mipsPkg::opBeq, 5'd23, 5'd21, 16'd2);
		rom[35] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd24, 16'd8);
		rom[36] = iTypeWord(mipsPkg::opAddiu, 5'd0, 5'd25, 16'd9);
		rom[37] = rTypeWord(5'd23, 5'd24, 5'd26, mipsPkg::fnAddu);
		rom[38] = iTypeWord(mipsPkg::opSw, 5'd10, 5'd26, 16'd20);
		rom[39] = iTypeWord(mipsPkg::opSw, 5'd10, 5'd0, 16'd24);
	endtask

	// Instruction-level model with one delay slot per branch
	task automatic runModel();
		logic [31:0] regs [0:31];
		logic [31:0] mem [0:63];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nnpc;
		logic [31:0] off;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] sext;
		logic [4:0] dest;
		logic [4:0] loadDest;
		logic [2:0] tag;
		logic wr;
		logic usesRt;
		logic isBr;
		logic prevBr;
		logic prev2Br;
		int steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = 32'd0;
		end
		for (int i = 0; i < 64; i++) begin
			mem[i] = fillWord(i);
		end
		pc = resetPc;
		npc = resetPc + 32'd4;
		loadDest = 5'd0;
		prevBr = 1'b0;
		prev2Br = 1'b0;
		steps = 0;
		while (((pc - resetPc) >> 2) < 32'(progLen) && steps < 200) begin
			off = (pc - resetPc) >> 2;
			ins = rom[off[5:0]];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			sext = {{16{ins[15]}}, ins[15:0]};
			nnpc = npc + 32'd4;
			dest = ins[20:16];
			res = 32'd0;
			wr = 1'b1;
			usesRt = 1'b0;
			isBr = 1'b0;
			case (ins[31:26])
				mipsPkg::opSpecial: begin
					dest = ins[15:11];
					usesRt = 1'b1;
					case (ins[5:0])
						mipsPkg::fnAddu: res = a + b;
						mipsPkg::fnSubu: res = a - b;
						mipsPkg::fnAnd:  res = a & b;
						mipsPkg::fnOr:   res = a | b;
						mipsPkg::fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default:         wr = 1'b0;
					endcase
				end
				mipsPkg::opAddiu: res = a + sext;
				mipsPkg::opOri:   res = a | {16'd0, ins[15:0]};
				mipsPkg::opLui:   res = {ins[15:0], 16'd0};
				mipsPkg::opLw: begin
					addr = a + sext;
					res = mem[addr[7:2]];
				end
				mipsPkg::opSw: begin
					wr = 1'b0;
					usesRt = 1'b1;
					addr = a + sext;
					mem[addr[7:2]] = b;
					expSt.push_back({addr, b});
				end
				mipsPkg::opBeq, mipsPkg::opBne: begin
					wr = 1'b0;
					usesRt = 1'b1;
					isBr = 1'b1;
					if ((a == b) == (ins[31:26] == mipsPkg::opBeq)) begin
						nnpc = pc + 32'd4 + {sext[29:0], 2'b00};
					end
				end
				default: wr = 1'b0;
			endcase
			// Tag picks the behavior each writeback counts toward
			if (loadDest != 5'd0 && (loadDest == ins[25:21] ||
					(usesRt && loadDest == ins[20:16]))) begin
				tag = 3'd3;
			end else if (ins[31:26] == mipsPkg::opSpecial &&
					(ins[25:21] == 5'd0 || ins[20:16] == 5'd0)) begin
				tag = 3'd6;
			end else if (prevBr || prev2Br) begin
				tag = 3'd5;
			end else begin
				tag = 3'd2;
			end
			if (wr) begin
				expWb.push_back({pc, dest, res, tag});
				if (dest != 5'd0) begin
					regs[dest] = res;
				end
			end
			loadDest = (ins[31:26] == mipsPkg::opLw) ? ins[20:16] : 5'd0;
			prev2Br = prevBr;
			prevBr = isBr;
			pc = npc;
			npc = nnpc;
			steps++;
		end
	endtask

	task automatic reportBehavior(input int k, input string name);
		$display("Behavior %0d, %s: %0d checks, %0d errors", k, name,
			passCnt[k] + failCnt[k], failCnt[k]);
	endtask

	// Instruction ROM with one cycle read latency
	always @(posedge clk) begin
		if (instSramEn) begin
			instSramRdata <= fetchWord(instSramAddr);
		end
	end

	// Data RAM of 64 words that returns the word from before the write
	always @(posedge clk) begin
		if (dataSramEn) begin
			for (int b = 0; b < 4; b++) begin
				if (dataSramWen[b]) begin
					ram[dataSramAddr[7:2]][8*b +: 8] <= dataSramWdata[8*b +: 8];
				end
			end
			dataSramRdata <= ram[dataSramAddr[7:2]];
		end
	end

	always @(posedge clk) begin
		if (!rstN) begin
			assert (!instSramEn && !dataSramEn && debugWbRfWen == 4'h0) passCnt[1]++;
			else begin
				$display("Error at %0d ns: an SRAM or writeback enable is set in reset", $time);
				failCnt[1]++;
			end
		end else if (!firstChecked) begin
			assert (instSramEn && !dataSramEn && debugWbRfWen == 4'h0 &&
				instSramAddr == resetPc) passCnt[1]++;
			else begin
				$display("Error at %0d ns: first cycle after reset fetches %h, enables %b %b %b",
					$time, instSramAddr, instSramEn, dataSramEn, debugWbRfWen);
				failCnt[1]++;
			end
			firstChecked = 1'b1;
		end else begin
			if (debugWbRfWen != 4'h0) begin
				if (expWb.size() == 0) begin
					$display("Unexpected writeback from pc %h after the last expected one", debugWbPc);
					failCnt[2]++;
				end else begin
					wantWb = expWb.pop_front();
					assert (debugWbRfWen == 4'hf && debugWbPc == wantWb.pc &&
						debugWbRfWnum == wantWb.num && debugWbRfWdata == wantWb.val)
						passCnt[wantWb.tag]++;
					else begin
						$display("Error at %0d ns: writeback pc %h r%0d = %h, expected pc %h r%0d = %h",
							$time, debugWbPc, debugWbRfWnum, debugWbRfWdata,
							wantWb.pc, wantWb.num, wantWb.val);
						failCnt[wantWb.tag]++;
					end
				end
			end
			if (dataSramEn && dataSramWen != 4'h0) begin
				if (expSt.size() == 0) begin
					$display("Unexpected store to %h after the last expected one", dataSramAddr);
					failCnt[4]++;
				end else begin
					wantSt = expSt.pop_front();
					assert (dataSramWen == 4'hf && dataSramAddr == wantSt.addr &&
						dataSramWdata == wantSt.data) passCnt[4]++;
					else begin
						$display("Error at %0d ns: store %h to %h wen %b, expected %h to %h",
							$time, dataSramWdata, dataSramAddr, dataSramWen,
							wantSt.data, wantSt.addr);
						failCnt[4]++;
					end
				end
			end
		end
	end

	initial begin
		int waited;
		int totalChecks;
		int totalErrors;
		loadProgram();
		runModel();
		waited = 0;
		while (!firstChecked && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (!firstChecked) begin
			$display("Reset was not released within 20 cycles");
			failCnt[1]++;
		end
		reportBehavior(1, "reset state");
		waited = 0;
		while ((expWb.size() > 0 || expSt.size() > 0) && waited < wbTimeout) begin
			@(negedge clk);
			waited++;
		end
		if (expWb.size() > 0 || expSt.size() > 0) begin
			$display("Timeout: %0d writebacks and %0d stores still missing after %0d cycles",
				expWb.size(), expSt.size(), wbTimeout);
			failCnt[3]++;
		end
		reportBehavior(2, "writeback order");
		reportBehavior(3, "load use");
		reportBehavior(4, "stores");
		reportBehavior(5, "branches");
		reportBehavior(6, "register zero");
		totalChecks = 0;
		totalErrors = 0;
		for (int k = 1; k <= 6; k++) begin
			totalChecks += passCnt[k] + failCnt[k];
			totalErrors += failCnt[k];
		end
		$display("Total: %0d checks, %0d errors", totalChecks, totalErrors);
		if (totalErrors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- mipsLite.f
source/mipsPkg.sv
source/stageIfs.sv
source/fetchStage.sv
source/regFile.sv
source/hazardUnit.sv
source/decodeStage.sv
source/executeStage.sv
source/memWbStage.sv
source/mipsLite.sv
dv/tbClock.sv
dv/mipsLiteTb.sv

//--- Makefile
TOP := mipsLiteTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f mipsLite.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f mipsLite.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null

clean:
	rm -rf obj_dir
